//--- Bender.yml
package:
  name: dmni

sources:
  - source/dmni_pkg.sv
  - source/dmni_cmd_decode.sv
  - source/dmni_send_engine.sv
  - source/dmni_receive_engine.sv
  - source/dmni_mem_arbiter.sv
  - source/dmni_top.sv
  - target: test
    files:
      - testbench/tb_dmni_mem.sv
      - testbench/tb_dmni.sv

//--- filelist.f
source/dmni_pkg.sv
source/dmni_cmd_decode.sv
source/dmni_send_engine.sv
source/dmni_receive_engine.sv
source/dmni_mem_arbiter.sv
source/dmni_top.sv
testbench/tb_dmni_mem.sv
testbench/tb_dmni.sv

//--- source/dmni_cmd_decode.sv
`timescale 1ns/1ps

module dmni_cmd_decode (
    input  logic                        clk_i,
    input  logic                        rst_ni,

    input  logic                        start_i,
    input  dmni_pkg::dmni_op_e          op_i,
    input  logic [dmni_pkg::ADDR_W-1:0] addr_i,
    input  logic [dmni_pkg::FLIT_W-1:0] size_i,
    input  logic [dmni_pkg::ADDR_W-1:0] addr2_i,
    input  logic [dmni_pkg::FLIT_W-1:0] size2_i,

    input  logic                        send_ready_i,
    input  logic                        recv_ready_i,

    output logic                        send_cmd_o,
    output logic                        recv_cmd_o,
    output dmni_pkg::dmni_desc_t        desc_o
);

    import dmni_pkg::*;

    logic send_go;
    logic recv_go;

    // an engine still reports ready during the cycle its strobe is out,
    // so a pending strobe also blocks a new command.
    assign send_go = start_i && (op_i == OP_SEND) && send_ready_i && !send_cmd_o;
    assign recv_go = start_i && (op_i == OP_RECEIVE) && recv_ready_i && !recv_cmd_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            send_cmd_o <= 1'b0;
            recv_cmd_o <= 1'b0;
        end else begin
            send_cmd_o <= send_go;
            recv_cmd_o <= recv_go;
        end
    end

    always_ff @(posedge clk_i) begin
        if (send_go || recv_go) begin
            desc_o.addr  <= addr_i;
            desc_o.size  <= size_i;
            desc_o.addr2 <= addr2_i;
            desc_o.size2 <= size2_i;
        end
    end

endmodule

//--- source/dmni_mem_arbiter.sv
`timescale 1ns/1ps

module dmni_mem_arbiter (
    input  logic                            clk_i,
    input  logic                            rst_ni,

    input  logic                            send_pending_i,
    input  logic                            recv_pending_i,
    input  dmni_pkg::mem_req_t              send_req_i,
    input  dmni_pkg::mem_req_t              recv_req_i,

    output logic                            send_grant_o,
    output logic                            recv_grant_o,

    output logic [dmni_pkg::ADDR_W-1:0]     mem_addr_o,
    output logic [dmni_pkg::FLIT_W-1:0]     mem_data_o,
    output logic [dmni_pkg::WORD_BYTES-1:0] mem_we_o
);

    import dmni_pkg::*;

    // ####################################################################
    // round-robin grant with hold timer
    // ####################################################################

    arb_src_e               owner_q;
    arb_src_e               other;
    arb_src_e               next_owner;
    logic [ARB_TIMER_W-1:0] timer_q;
    logic [1:0]             pending;
    logic                   rearbitrate;

    assign pending[SRC_SEND]    = send_pending_i;
    assign pending[SRC_RECEIVE] = recv_pending_i;

    assign other      = (owner_q == SRC_SEND) ? SRC_RECEIVE : SRC_SEND;
    assign next_owner = pending[other] ? other : owner_q;

    // the owner keeps the port until its time is up or it goes idle.
    assign rearbitrate = (|pending) && ((timer_q == '0) || !pending[owner_q]);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            owner_q <= SRC_SEND;
            timer_q <= '0;
        end else begin
            if (timer_q != '0) begin
                timer_q <= timer_q - ARB_TIMER_W'(1);
            end
            if (rearbitrate) begin
                owner_q <= next_owner;
                timer_q <= ARB_TIMER_W'(ARB_HOLD_CYCLES);
            end
        end
    end

    assign send_grant_o = (owner_q == SRC_SEND);
    assign recv_grant_o = (owner_q == SRC_RECEIVE);

    // ####################################################################
    // memory port
    // ####################################################################

    mem_req_t granted;

    assign granted = (owner_q == SRC_SEND) ? send_req_i : recv_req_i;

    assign mem_addr_o = granted.addr;
    assign mem_data_o = granted.wdata;
    assign mem_we_o   = {WORD_BYTES{granted.write}};

endmodule

//--- source/dmni_pkg.sv
package dmni_pkg;

    // ####################################################################
    // widths and timing constants
    // ####################################################################

    // the flit width is also the memory data width.
    localparam int FLIT_W = 32;

    localparam int ADDR_W = 32;

    // address step between consecutive words.
    localparam int WORD_BYTES = 4;

    // cycles a grant is kept while another source waits.
    localparam int ARB_HOLD_CYCLES = 15;
    localparam int ARB_TIMER_W     = $clog2(ARB_HOLD_CYCLES + 1);

    // ####################################################################
    // enumerations
    // ####################################################################

    typedef enum logic {
        OP_SEND,
        OP_RECEIVE
    } dmni_op_e;

    typedef enum logic {
        SEND_IDLE,
        SEND_DATA
    } send_state_e;

    typedef enum logic [1:0] {
        RECV_HEADER,
        RECV_SIZE,
        RECV_WAIT,
        RECV_DATA
    } recv_state_e;

    typedef enum logic {
        SRC_SEND,
        SRC_RECEIVE
    } arb_src_e;

    // ####################################################################
    // structures
    // ####################################################################

    // the receive engine only looks at addr and size.
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [FLIT_W-1:0] size;
        logic [ADDR_W-1:0] addr2;
        logic [FLIT_W-1:0] size2;
    } dmni_desc_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [FLIT_W-1:0] wdata;
        logic              write;
    } mem_req_t;

endpackage

//--- source/dmni_receive_engine.sv
`timescale 1ns/1ps

module dmni_receive_engine (
    input  logic                        clk_i,
    input  logic                        rst_ni,

    input  logic                        cmd_i,
    input  dmni_pkg::dmni_desc_t        desc_i,
    input  logic                        grant_i,
    input  logic                        noc_rx_i,
    input  logic [dmni_pkg::FLIT_W-1:0] noc_data_i,

    output logic                        ready_o,
    output logic                        pending_o,
    output dmni_pkg::mem_req_t          req_o,
    output logic                        noc_credit_o,
    output logic                        active_o
);

    import dmni_pkg::*;

    recv_state_e       state_q;
    logic [FLIT_W-1:0] payload_q;
    logic [ADDR_W-1:0] buf_addr_q;
    logic [FLIT_W-1:0] buf_size_q;

    logic accept;

    // a payload flit is taken only while the memory port is ours.
    assign accept = (state_q == RECV_DATA) && noc_rx_i && grant_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= RECV_HEADER;
            payload_q  <= '0;
            buf_addr_q <= '0;
            buf_size_q <= '0;
        end else begin
            case (state_q)
                RECV_HEADER: begin
                    if (noc_rx_i) begin
                        state_q <= RECV_SIZE;
                    end
                end
                RECV_SIZE: begin
                    if (noc_rx_i) begin
                        payload_q <= noc_data_i;
                        // a packet without payload ends here.
                        if (noc_data_i == '0) begin
                            state_q <= RECV_HEADER;
                        end else begin
                            state_q <= RECV_WAIT;
                        end
                    end
                end
                RECV_WAIT: begin
                    if (cmd_i) begin
                        buf_addr_q <= desc_i.addr;
                        buf_size_q <= desc_i.size;
                        if (desc_i.size != '0) begin
                            state_q <= RECV_DATA;
                        end
                    end
                end
                RECV_DATA: begin
                    if (accept) begin
                        buf_addr_q <= buf_addr_q + ADDR_W'(WORD_BYTES);
                        buf_size_q <= buf_size_q - FLIT_W'(1);
                        payload_q  <= payload_q - FLIT_W'(1);
                        if (payload_q == FLIT_W'(1)) begin
                            state_q <= RECV_HEADER;
                        end else if (buf_size_q == FLIT_W'(1)) begin
                            state_q <= RECV_WAIT;
                        end
                    end
                end
                default: state_q <= RECV_HEADER;
            endcase
        end
    end

    always_comb begin
        case (state_q)
            RECV_DATA: noc_credit_o = noc_rx_i && grant_i;
            RECV_WAIT: noc_credit_o = 1'b0;
            default:   noc_credit_o = 1'b1;
        endcase
    end

    always_comb begin
        req_o.addr  = buf_addr_q;
        req_o.wdata = noc_data_i;
        req_o.write = (state_q == RECV_DATA) && noc_rx_i;
    end

    assign ready_o   = (state_q == RECV_WAIT);
    assign pending_o = (state_q == RECV_DATA);
    assign active_o  = (state_q == RECV_DATA);

endmodule

//--- source/dmni_send_engine.sv
`timescale 1ns/1ps

module dmni_send_engine (
    input  logic                        clk_i,
    input  logic                        rst_ni,

    input  logic                        cmd_i,
    input  dmni_pkg::dmni_desc_t        desc_i,
    input  logic                        grant_i,
    input  logic                        noc_ack_i,
    input  logic [dmni_pkg::FLIT_W-1:0] mem_data_i,

    output logic                        ready_o,
    output logic                        pending_o,
    output dmni_pkg::mem_req_t          req_o,
    output logic                        noc_tx_o,
    output logic [dmni_pkg::FLIT_W-1:0] noc_data_o,
    output logic                        active_o
);

    import dmni_pkg::*;

    send_state_e       state_q;
    logic [ADDR_W-1:0] addr_q;
    logic [ADDR_W-1:0] addr2_q;
    logic [FLIT_W-1:0] size_q;
    logic [FLIT_W-1:0] size2_q;

    logic transfer;
    logic first_seg;
    logic last_word;

    assign transfer  = (state_q == SEND_DATA) && grant_i && noc_ack_i;
    assign first_seg = (size_q != '0);
    assign last_word = first_seg ? (size_q == FLIT_W'(1) && size2_q == '0)
                                 : (size2_q == FLIT_W'(1));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= SEND_IDLE;
            addr_q  <= '0;
            addr2_q <= '0;
            size_q  <= '0;
            size2_q <= '0;
        end else begin
            case (state_q)
                SEND_IDLE: begin
                    if (cmd_i) begin
                        addr_q  <= desc_i.addr;
                        addr2_q <= desc_i.addr2;
                        size_q  <= desc_i.size;
                        size2_q <= desc_i.size2;
                        // an empty transfer completes right away.
                        if (desc_i.size != '0 || desc_i.size2 != '0) begin
                            state_q <= SEND_DATA;
                        end
                    end
                end
                SEND_DATA: begin
                    if (transfer) begin
                        if (first_seg) begin
                            addr_q <= addr_q + ADDR_W'(WORD_BYTES);
                            size_q <= size_q - FLIT_W'(1);
                        end else begin
                            addr2_q <= addr2_q + ADDR_W'(WORD_BYTES);
                            size2_q <= size2_q - FLIT_W'(1);
                        end
                        if (last_word) begin
                            state_q <= SEND_IDLE;
                        end
                    end
                end
                default: state_q <= SEND_IDLE;
            endcase
        end
    end

    always_comb begin
        req_o.addr  = first_seg ? addr_q : addr2_q;
        req_o.wdata = '0;
        req_o.write = 1'b0;
    end

    assign ready_o    = (state_q == SEND_IDLE);
    assign pending_o  = (state_q == SEND_DATA);
    assign active_o   = (state_q == SEND_DATA);
    // the flit on the network is the word read through the granted port.
    assign noc_tx_o   = (state_q == SEND_DATA) && grant_i;
    assign noc_data_o = mem_data_i;

endmodule

//--- source/dmni_top.sv
`timescale 1ns/1ps

module dmni_top (
    input  logic                            clk_i,
    input  logic                            rst_ni,

    input  logic                            start_i,
    input  dmni_pkg::dmni_op_e              op_i,
    input  logic [dmni_pkg::ADDR_W-1:0]     addr_i,
    input  logic [dmni_pkg::FLIT_W-1:0]     size_i,
    input  logic [dmni_pkg::ADDR_W-1:0]     addr2_i,
    input  logic [dmni_pkg::FLIT_W-1:0]     size2_i,
    output logic                            send_active_o,
    output logic                            receive_active_o,

    input  logic                            noc_rx_i,
    input  logic [dmni_pkg::FLIT_W-1:0]     noc_data_i,
    output logic                            noc_credit_o,

    output logic                            noc_tx_o,
    output logic [dmni_pkg::FLIT_W-1:0]     noc_data_o,
    input  logic                            noc_ack_i,

    output logic [dmni_pkg::ADDR_W-1:0]     mem_addr_o,
    output logic [dmni_pkg::FLIT_W-1:0]     mem_data_o,
    output logic [dmni_pkg::WORD_BYTES-1:0] mem_we_o,
    input  logic [dmni_pkg::FLIT_W-1:0]     mem_data_i
);

    import dmni_pkg::*;

    logic       send_ready, recv_ready;
    logic       send_cmd, recv_cmd;
    logic       send_pending, recv_pending;
    logic       send_grant, recv_grant;
    dmni_desc_t desc;
    mem_req_t   send_req, recv_req;

    dmni_cmd_decode u_decode (
        .clk_i, .rst_ni, .start_i, .op_i, .addr_i, .size_i, .addr2_i, .size2_i,
        .send_ready_i (send_ready), .recv_ready_i (recv_ready),
        .send_cmd_o   (send_cmd),   .recv_cmd_o   (recv_cmd),
        .desc_o       (desc)
    );

    dmni_send_engine u_send (
        .clk_i, .rst_ni, .cmd_i (send_cmd), .desc_i (desc), .grant_i (send_grant),
        .noc_ack_i, .mem_data_i, .ready_o (send_ready), .pending_o (send_pending),
        .req_o (send_req), .noc_tx_o, .noc_data_o, .active_o (send_active_o)
    );

    dmni_receive_engine u_receive (
        .clk_i, .rst_ni, .cmd_i (recv_cmd), .desc_i (desc), .grant_i (recv_grant),
        .noc_rx_i, .noc_data_i, .ready_o (recv_ready), .pending_o (recv_pending),
        .req_o (recv_req), .noc_credit_o, .active_o (receive_active_o)
    );

    dmni_mem_arbiter u_arbiter (
        .clk_i, .rst_ni,
        .send_pending_i (send_pending), .recv_pending_i (recv_pending),
        .send_req_i     (send_req),     .recv_req_i     (recv_req),
        .send_grant_o   (send_grant),   .recv_grant_o   (recv_grant),
        .mem_addr_o, .mem_data_o, .mem_we_o
    );

endmodule

//--- testbench/tb_dmni.sv
`timescale 1ns/1ps

module tb_dmni;

    import dmni_pkg::*;

    localparam logic [31:0] SEED           = 32'ha8e2;
    localparam int          TIMEOUT_CYCLES = 300;

    logic                  clk_i, rst_ni, start_i;
    dmni_op_e              op_i;
    logic [ADDR_W-1:0]     addr_i, addr2_i, mem_addr_o;
    logic [FLIT_W-1:0]     size_i, size2_i, noc_data_i, noc_data_o, mem_data_o, mem_data_i;
    logic                  send_active_o, receive_active_o;
    logic                  noc_rx_i, noc_credit_o, noc_tx_o, noc_ack_i;
    logic [WORD_BYTES-1:0] mem_we_o;

    int          errors      = 0;
    int          checks      = 0;
    int          test_errors = 0;
    logic [31:0] rx_lcg;
    logic [31:0] sent_q[$];

    dmni_top UUT (.*);

    tb_dmni_mem u_mem (
        .clk_i, .addr_i (mem_addr_o), .wdata_i (mem_data_o), .we_i (mem_we_o),
        .rdata_o (mem_data_i)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] payload_word(input int tag, input int idx);
        return 32'h5a00_0000 | (32'(tag) << 12) | 32'(idx);
    endfunction

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // the next router acks about three flits out of four.
    initial begin : ack_driver
        logic [31:0] ack_lcg;
        ack_lcg   = SEED;
        noc_ack_i = 1'b0;
        forever begin
            @(posedge clk_i);
            #2;
            ack_lcg   = lcg_next(ack_lcg);
            noc_ack_i = (ack_lcg[17:16] != 2'b00);
        end
    end

    always @(negedge clk_i) begin
        if (rst_ni && noc_tx_o && noc_ack_i) begin
            sent_q.push_back(noc_data_o);
        end
    end

    // a memory write is always a full word taken from an accepted flit.
    assert property (@(posedge clk_i) disable iff (!rst_ni)
                     (mem_we_o != '0) |->
                     (mem_we_o == 4'hF && noc_credit_o && receive_active_o && !noc_tx_o))
        else begin
            errors++;
            $display("Mismatch at %0t: memory write without an accepted flit", $time);
        end

    // ####################################################################
    // stimulus and checking tasks
    // ####################################################################

    task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %-18s done, %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    task automatic wait_active(input bit send, input logic level);
        int n;
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
        end while (((send ? send_active_o : receive_active_o) !== level) && n < TIMEOUT_CYCLES);
        if ((send ? send_active_o : receive_active_o) !== level) begin
            errors++;
            $display("timeout: the %s engine never became %s", send ? "send" : "receive",
                     level ? "active" : "idle");
        end
    endtask

    // holds rx high until the DMNI gives credit, after a random idle gap.
    task automatic put_flit(input logic [31:0] data);
        int n;
        rx_lcg = lcg_next(rx_lcg);
        repeat (rx_lcg[21:20]) @(posedge clk_i);
        @(posedge clk_i);
        #2;
        noc_rx_i   = 1'b1;
        noc_data_i = data;
        n = 0;
        @(negedge clk_i);
        while (!noc_credit_o && n < TIMEOUT_CYCLES) begin
            @(negedge clk_i);
            n++;
        end
        if (!noc_credit_o) begin
            errors++;
            $display("timeout: flit %h was never given credit", data);
        end
        @(posedge clk_i);
        #2;
        noc_rx_i = 1'b0;
    endtask

    task automatic issue_cmd(input dmni_op_e op, input logic [31:0] addr,
                             input logic [31:0] size, input logic [31:0] addr2,
                             input logic [31:0] size2);
        @(posedge clk_i);
        #2;
        start_i = 1'b1;
        op_i    = op;
        addr_i  = addr;
        size_i  = size;
        addr2_i = addr2;
        size2_i = size2;
        @(posedge clk_i);
        #2;
        start_i = 1'b0;
    endtask

    task automatic preload_seg(input logic [31:0] addr, input int tag, input int count);
        for (int i = 0; i < count; i++) begin
            u_mem.preload_word(addr + 32'(4 * i), payload_word(tag, i));
        end
    endtask

    task automatic check_sent(input int first, input int tag, input int count);
        for (int i = 0; i < count; i++) begin
            if (first + i < sent_q.size()) begin
                expect_eq(sent_q[first + i], payload_word(tag, i),
                          $sformatf("sent flit %0d", first + i));
            end
        end
    endtask

    task automatic check_words(input logic [31:0] addr, input int tag, input int first,
                               input int count);
        logic [31:0] word;
        for (int i = 0; i < count; i++) begin
            u_mem.peek_word(addr + 32'(4 * i), word);
            expect_eq(word, payload_word(tag, first + i),
                      $sformatf("memory word at %h", addr + 32'(4 * i)));
        end
    endtask

    // ####################################################################
    // test sequence
    // ####################################################################

    initial begin
        rst_ni     = 1'b0;
        start_i    = 1'b0;
        op_i       = OP_SEND;
        addr_i     = '0;
        size_i     = '0;
        addr2_i    = '0;
        size2_i    = '0;
        noc_rx_i   = 1'b0;
        noc_data_i = '0;
        rx_lcg     = lcg_next(SEED);
        repeat (2) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;

        @(negedge clk_i);
        expect_eq(noc_tx_o, 1'b0, "noc_tx_o after reset");
        expect_eq(mem_we_o, '0, "mem_we_o after reset");
        expect_eq(send_active_o, 1'b0, "send_active_o after reset");
        expect_eq(receive_active_o, 1'b0, "receive_active_o after reset");
        expect_eq(noc_credit_o, 1'b1, "noc_credit_o after reset");
        finish_test("reset");

        preload_seg(32'h040, 1, 3);
        preload_seg(32'h100, 2, 2);
        sent_q.delete();
        issue_cmd(OP_SEND, 32'h040, 3, 32'h100, 2);
        wait_active(1'b1, 1'b1);
        wait_active(1'b1, 1'b0);
        expect_eq(sent_q.size(), 5, "number of sent flits");
        check_sent(0, 1, 3);
        check_sent(3, 2, 2);
        finish_test("two-segment send");

        put_flit(32'h0000_0100);
        put_flit(32'd4);
        repeat (2) begin
            @(negedge clk_i);
            expect_eq(noc_credit_o, 1'b0, "credit while waiting for a buffer");
        end
        issue_cmd(OP_RECEIVE, 32'h200, 4, '0, '0);
        for (int i = 0; i < 4; i++) begin
            put_flit(payload_word(3, i));
        end
        wait_active(1'b0, 1'b0);
        check_words(32'h200, 3, 0, 4);
        finish_test("receive");

        put_flit(32'h0000_0200);
        put_flit(32'd4);
        issue_cmd(OP_RECEIVE, 32'h280, 2, '0, '0);
        put_flit(payload_word(4, 0));
        put_flit(payload_word(4, 1));
        repeat (3) begin
            @(negedge clk_i);
            expect_eq(receive_active_o, 1'b0, "receive_active_o on a full buffer");
            expect_eq(noc_credit_o, 1'b0, "credit on a full buffer");
        end
        issue_cmd(OP_RECEIVE, 32'h2c0, 2, '0, '0);
        put_flit(payload_word(4, 2));
        put_flit(payload_word(4, 3));
        wait_active(1'b0, 1'b0);
        check_words(32'h280, 4, 0, 2);
        check_words(32'h2c0, 4, 2, 2);
        finish_test("split buffer");

        // a long send keeps the port busy past the hold time.
        preload_seg(32'h300, 5, 12);
        preload_seg(32'h080, 6, 8);
        sent_q.delete();
        put_flit(32'h0000_0300);
        put_flit(32'd12);
        issue_cmd(OP_SEND, 32'h300, 12, 32'h080, 8);
        wait_active(1'b1, 1'b1);
        issue_cmd(OP_RECEIVE, 32'h380, 12, '0, '0);
        fork
            wait_active(1'b1, 1'b0);
            begin
                for (int i = 0; i < 12; i++) begin
                    put_flit(payload_word(7, i));
                end
                wait_active(1'b0, 1'b0);
            end
        join
        expect_eq(sent_q.size(), 20, "number of sent flits");
        check_sent(0, 5, 12);
        check_sent(12, 6, 8);
        check_words(32'h380, 7, 0, 12);
        finish_test("concurrent traffic");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- testbench/tb_dmni_mem.sv
`timescale 1ns/1ps

module tb_dmni_mem (
    input  logic        clk_i,
    input  logic [31:0] addr_i,
    input  logic [31:0] wdata_i,
    input  logic [3:0]  we_i,
    output logic [31:0] rdata_o
);

    // the model holds 256 words and is indexed by the word bits of the byte address.
    logic [31:0] mem [256];

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'hc0de_0000 ^ 32'(4 * i);
        end
    end

    assign rdata_o = mem[addr_i[9:2]];

    always @(posedge clk_i) begin
        for (int b = 0; b < 4; b++) begin
            if (we_i[b]) begin
                mem[addr_i[9:2]][8*b +: 8] <= wdata_i[8*b +: 8];
            end
        end
    end

    task automatic preload_word(input logic [31:0] addr, input logic [31:0] data);
        mem[addr[9:2]] = data;
    endtask

    task automatic peek_word(input logic [31:0] addr, output logic [31:0] data);
        data = mem[addr[9:2]];
    endtask

endmodule
